// ==== Makefile ====
BUILD_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 -f y86_core.f \
		--top-module y86_core_tb --Mdir $(BUILD_DIR) -o y86_core_sim

run: compile
	./$(BUILD_DIR)/y86_core_sim

clean:
	rm -rf $(BUILD_DIR)

// ==== src/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit (
    input  logic                    clk,
    input  logic                    reset,
    input  y86_pkg::decoded_instr_t dec,
    input  y86_pkg::word_t          vala,
    input  y86_pkg::word_t          valb,
    output y86_pkg::cond_codes_t    cc,
    output logic                    wb_en,
    output y86_pkg::reg_id_t        wb_reg,
    output y86_pkg::word_t          wb_val
);
    import y86_pkg::*;

    word_t       alu_out;
    logic        alu_of;
    logic        is_opq;
    logic        writes_rb;
    cond_codes_t cc_next;

    // ISA order, rB op rA
    always_comb begin
        alu_out = '0;
        alu_of  = 1'b0;
        case (alu_fn_t'(dec.ifun))
            fn_add: begin
                alu_out = valb + vala;
                alu_of  = (vala[WORD_BITS-1] == valb[WORD_BITS-1])
                          && (alu_out[WORD_BITS-1] != valb[WORD_BITS-1]);
            end
            fn_sub: begin
                alu_out = valb - vala;
                // operands of opposite sign, result flips away from rB
                alu_of  = (vala[WORD_BITS-1] != valb[WORD_BITS-1])
                          && (alu_out[WORD_BITS-1] != valb[WORD_BITS-1]);
            end
            fn_and:  alu_out = valb & vala;
            fn_xor:  alu_out = valb ^ vala;
            default: alu_out = '0; // filtered out by fetch
        endcase
    end

    assign cc_next = '{
        zf: alu_out == '0,
        sf: alu_out[WORD_BITS-1],
        of: alu_of
    };

    assign is_opq = dec.icode == 4'(op_opq);

    always_comb begin
        writes_rb = 1'b0;
        wb_val    = alu_out;
        case (dec.icode)
            op_rrmovq: begin
                writes_rb = 1'b1;
                wb_val    = vala;
            end
            op_irmovq: begin
                writes_rb = 1'b1;
                wb_val    = dec.valc;
            end
            op_opq:  writes_rb = 1'b1;
            default: writes_rb = 1'b0; // halt, nop
        endcase
    end

    assign wb_en  = dec.valid && writes_rb && dec.rb != REG_NONE;
    assign wb_reg = dec.rb;

    always_ff @(posedge clk) begin
        if (reset) begin
            cc <= '{zf: 1'b1, sf: 1'b0, of: 1'b0};
        end else if (dec.valid && is_opq) begin
            cc <= cc_next; // only opq touches flags
        end
    end

endmodule

// ==== src/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit #(
    parameter int MEM_BYTES = 1024
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         run,
    input  logic                         load_en,
    input  logic [$clog2(MEM_BYTES)-1:0] load_addr,
    input  logic [7:0]                   load_byte,
    output y86_pkg::word_t               pc,
    output y86_pkg::status_t             status,
    output y86_pkg::decoded_instr_t      dec
);
    import y86_pkg::*;

    logic [FETCH_BYTES-1:0][7:0] window;
    logic                        window_ok;
    logic [3:0]                  icode;
    logic [3:0]                  ifun;
    logic [3:0]                  ilen;
    logic                        is_halt;
    logic                        is_bad;
    logic                        active;
    word_t                       next_pc;

    instr_memory #(
        .MEM_BYTES(MEM_BYTES)
    ) instr_memory_inst (
        .clk        (clk),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_byte  (load_byte),
        .fetch_addr (pc),
        .window     (window),
        .window_ok  (window_ok)
    );

    // first fetched byte sits in the top slot
    assign icode = window[FETCH_BYTES-1][7:4];
    assign ifun  = window[FETCH_BYTES-1][3:0];

    // length and legality per opcode
    always_comb begin
        ilen   = 4'd1;
        is_bad = 1'b0;
        case (icode)
            op_halt, op_nop: ilen = 4'd1;
            op_rrmovq:       ilen = 4'd2;
            op_irmovq:       ilen = 4'd10;
            op_opq: begin
                ilen   = 4'd2;
                is_bad = ifun > 4'(fn_xor); // only four alu functions
            end
            default:         is_bad = 1'b1;
        endcase
    end

    assign is_halt = icode == 4'(op_halt);
    assign active  = run && (status == stat_aok);
    assign next_pc = pc + word_t'(ilen);

    assign dec = '{
        icode: icode,
        ifun:  ifun,
        ra:    window[FETCH_BYTES-2][7:4],
        rb:    window[FETCH_BYTES-2][3:0],
        valc:  window[FETCH_BYTES-3:0], // bytes 2..9, big-endian
        valid: active && window_ok && !is_bad
    };

    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= '0;
            status <= stat_aok;
        end else if (active) begin
            // address fault wins, window bytes are meaningless then
            if (!window_ok) begin
                status <= stat_adr;
            end else if (is_bad) begin
                status <= stat_ins;
            end else if (is_halt) begin
                status <= stat_hlt; // pc stays on the halt
            end else begin
                pc <= next_pc;
            end
        end
    end

    // program load and execution never overlap
    a_no_load_while_run: assert property (
        @(posedge clk) disable iff (reset) load_en |-> !run
    );

endmodule

// ==== src/instr_memory.sv ====
`timescale 1ns/1ps

module instr_memory #(
    parameter int MEM_BYTES = 1024
) (
    input  logic                                  clk,
    input  logic                                  load_en,
    input  logic [$clog2(MEM_BYTES)-1:0]          load_addr,
    input  logic [7:0]                            load_byte,
    input  y86_pkg::word_t                        fetch_addr,
    output logic [y86_pkg::FETCH_BYTES-1:0][7:0]  window,
    output logic                                  window_ok
);
    import y86_pkg::*;

    localparam int ADDR_BITS = $clog2(MEM_BYTES);

    logic [7:0]           mem [MEM_BYTES];
    logic [ADDR_BITS-1:0] base;

    // program load port
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_byte;
        end
    end

    // last byte of the window must still be inside memory
    assign window_ok = fetch_addr < word_t'(MEM_BYTES - FETCH_BYTES + 1);
    assign base      = fetch_addr[ADDR_BITS-1:0];

    always_comb begin
        window = '0;
        if (window_ok) begin
            for (int i = 0; i < FETCH_BYTES; i++) begin
                // lowest address lands in the top byte
                window[FETCH_BYTES-1-i] = mem[base + ADDR_BITS'(i)];
            end
        end
    end

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                    clk,
    input  logic                    reset,
    input  y86_pkg::decoded_instr_t dec,
    input  logic                    wb_en,
    input  y86_pkg::reg_id_t        wb_reg,
    input  y86_pkg::word_t          wb_val,
    output y86_pkg::word_t          vala,
    output y86_pkg::word_t          valb
);
    import y86_pkg::*;

    localparam int NUM_REGS = 15;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_reg != REG_NONE) begin
            regs[wb_reg] <= wb_val;
        end
    end

    // no register reads as zero
    always_comb begin
        vala = '0;
        valb = '0;
        if (dec.ra != REG_NONE) begin
            vala = regs[dec.ra];
        end
        if (dec.rb != REG_NONE) begin
            valb = regs[dec.rb];
        end
    end

    // execute must drop writes whose destination is F
    a_no_write_to_none: assert property (
        @(posedge clk) disable iff (reset) wb_en |-> wb_reg != REG_NONE
    );

endmodule

// ==== src/y86_core.sv ====
`timescale 1ns/1ps

module y86_core #(
    parameter int MEM_BYTES = 1024
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         run,
    input  logic                         load_en,
    input  logic [$clog2(MEM_BYTES)-1:0] load_addr,
    input  logic [7:0]                   load_byte,
    output y86_pkg::word_t               pc,
    output y86_pkg::status_t             status,
    output y86_pkg::cond_codes_t         cc,
    output logic                         wb_en,
    output y86_pkg::reg_id_t             wb_reg,
    output y86_pkg::word_t               wb_val
);
    import y86_pkg::*;

    decoded_instr_t dec;
    word_t          vala;
    word_t          valb;

    // pc, status and the decoded instruction
    fetch_unit #(
        .MEM_BYTES(MEM_BYTES)
    ) fetch_unit_inst (
        .clk       (clk),
        .reset     (reset),
        .run       (run),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_byte (load_byte),
        .pc        (pc),
        .status    (status),
        .dec       (dec)
    );

    reg_file reg_file_inst (
        .clk    (clk),
        .reset  (reset),
        .dec    (dec),
        .wb_en  (wb_en),
        .wb_reg (wb_reg),
        .wb_val (wb_val),
        .vala   (vala),
        .valb   (valb)
    );

    // alu and writeback, result goes back to the register file
    execute_unit execute_unit_inst (
        .clk    (clk),
        .reset  (reset),
        .dec    (dec),
        .vala   (vala),
        .valb   (valb),
        .cc     (cc),
        .wb_en  (wb_en),
        .wb_reg (wb_reg),
        .wb_val (wb_val)
    );

endmodule

// ==== src/y86_pkg.sv ====
package y86_pkg;

    localparam int WORD_BITS = 64;
    localparam int FETCH_BYTES = 10;   // longest instruction, irmovq

    typedef logic [WORD_BITS-1:0] word_t;

    // register specifier, code F means no register
    typedef logic [3:0] reg_id_t;

    localparam reg_id_t REG_NONE = 4'hF;

    // instruction codes, upper nibble of the first byte
    typedef enum logic [3:0] {
        op_halt   = 4'h0,
        op_nop    = 4'h1,
        op_rrmovq = 4'h2,
        op_irmovq = 4'h3,
        op_opq    = 4'h6
    } opcode_t;

    // opq function codes, lower nibble of the first byte
    typedef enum logic [3:0] {
        fn_add = 4'h0,
        fn_sub = 4'h1,
        fn_and = 4'h2,
        fn_xor = 4'h3
    } alu_fn_t;

    typedef enum logic [1:0] {
        stat_aok, // running normally
        stat_hlt,
        stat_adr, // fetch window past end of memory
        stat_ins  // undefined instruction
    } status_t;

    typedef struct packed {
        logic zf;
        logic sf;
        logic of;
    } cond_codes_t;

    typedef struct packed {
        logic [3:0] icode;
        logic [3:0] ifun;
        reg_id_t    ra;
        reg_id_t    rb;
        word_t      valc;  // big-endian immediate
        logic       valid; // executes this cycle
    } decoded_instr_t;

endpackage

// ==== tests/y86_core_tb.sv ====
`timescale 1ns/1ps

module y86_core_tb;
    import y86_pkg::*;

    localparam int MEM_BYTES       = 256;
    localparam int ADDR_BITS       = $clog2(MEM_BYTES);
    localparam int CLK_PERIOD      = 8;
    localparam int WATCHDOG_CYCLES = 2500; // tests take about 900 cycles

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 run;
    logic                 load_en;
    logic [ADDR_BITS-1:0] load_addr;
    logic [7:0]           load_byte;
    word_t                pc;
    status_t              status;
    cond_codes_t          cc;
    logic                 wb_en;
    reg_id_t              wb_reg;
    word_t                wb_val;

    logic [7:0]  prog [$];         // program being assembled
    logic [7:0]  image [MEM_BYTES]; // what the DUT memory holds

    // reference model state
    word_t       model_regs [15];
    word_t       model_pc;
    status_t     model_status;
    cond_codes_t model_cc;
    word_t       rng_state = 64'd52637;

    y86_core #(
        .MEM_BYTES(MEM_BYTES)
    ) y86_core_inst (
        .clk       (clk),
        .reset     (reset),
        .run       (run),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_byte (load_byte),
        .pc        (pc),
        .status    (status),
        .cc        (cc),
        .wb_en     (wb_en),
        .wb_reg    (wb_reg),
        .wb_val    (wb_val)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic word_t xorshift64();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 7);
        rng_state = rng_state ^ (rng_state << 17);
        return rng_state;
    endfunction

    task automatic fail_run();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_word(word_t got, word_t exp, string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
            fail_run();
        end
    endtask

    task automatic check_reg(reg_id_t got, reg_id_t exp, string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
            fail_run();
        end
    endtask

    task automatic check_status(status_t got, status_t exp, string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %s, expected %s", $time, what,
                     got.name(), exp.name());
            fail_run();
        end
    endtask

    task automatic check_cc(cond_codes_t got, cond_codes_t exp, string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %b, expected %b (zf sf of)", $time, what,
                     got, exp);
            fail_run();
        end
    endtask

    task automatic check_flag(logic got, logic exp, string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
            fail_run();
        end
    endtask

    // one assembler task per instruction form
    task automatic raw_byte(logic [7:0] b);
        prog.push_back(b);
    endtask

    task automatic halt_instr();
        prog.push_back(8'h00);
    endtask

    task automatic nop_instr();
        prog.push_back(8'h10);
    endtask

    task automatic rrmovq_instr(reg_id_t ra, reg_id_t rb);
        prog.push_back(8'h20);
        prog.push_back({ra, rb});
    endtask

    task automatic irmovq_instr(reg_id_t rb, word_t val);
        prog.push_back(8'h30);
        prog.push_back({REG_NONE, rb});
        for (int i = 7; i >= 0; i--) begin
            prog.push_back(val[i*8 +: 8]); // most significant byte first
        end
    endtask

    task automatic opq_instr(alu_fn_t fn, reg_id_t ra, reg_id_t rb);
        prog.push_back({op_opq, fn});
        prog.push_back({ra, rb});
    endtask

    task automatic reset_core();
        @(posedge clk);
        reset   <= 1'b1;
        run     <= 1'b0;
        load_en <= 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        foreach (model_regs[i]) begin
            model_regs[i] = '0;
        end
        model_pc     = '0;
        model_status = stat_aok;
        model_cc     = '{zf: 1'b1, sf: 1'b0, of: 1'b0};
    endtask

    task automatic load_program();
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= ADDR_BITS'(i);
            load_byte <= prog[i];
            image[i] = prog[i];
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    function automatic word_t model_read(reg_id_t r);
        return (r == REG_NONE) ? '0 : model_regs[r];
    endfunction

    // predicts the coming edge from the loaded bytes and checks its writeback
    task automatic step_model();
        logic [7:0]  b0;
        logic [7:0]  b1;
        logic [3:0]  icode;
        logic [3:0]  ifun;
        reg_id_t     ra;
        reg_id_t     rb;
        word_t       va;
        word_t       vb;
        word_t       valc;
        word_t       res;
        logic [64:0] wide;
        logic        exp_wb;
        int          len;
        int          addr;
        status_t     next_status;
        cond_codes_t next_cc;

        exp_wb      = 1'b0;
        res         = '0;
        rb          = REG_NONE;
        len         = 0;
        next_status = stat_aok;
        next_cc     = model_cc;
        addr        = int'(model_pc);
        if (model_pc > word_t'(MEM_BYTES - FETCH_BYTES)) begin
            next_status = stat_adr;
        end else begin
            b0    = image[addr];
            b1    = image[addr + 1];
            icode = b0[7:4];
            ifun  = b0[3:0];
            ra    = b1[7:4];
            rb    = b1[3:0];
            va    = model_read(ra);
            vb    = model_read(rb);
            valc  = '0;
            for (int i = 0; i < 8; i++) begin
                valc = {valc[55:0], image[addr + 2 + i]};
            end
            case (icode)
                4'(op_halt): next_status = stat_hlt;
                4'(op_nop):  len = 1;
                4'(op_rrmovq): begin
                    len    = 2;
                    exp_wb = 1'b1;
                    res    = va;
                end
                4'(op_irmovq): begin
                    len    = 10;
                    exp_wb = 1'b1;
                    res    = valc;
                end
                4'(op_opq): begin
                    if (ifun > 4'd3) begin
                        next_status = stat_ins;
                    end else begin
                        len    = 2;
                        exp_wb = 1'b1;
                        // overflow when the 65-bit signed result does not fit in 64
                        case (ifun)
                            4'(fn_add): wide = {vb[63], vb} + {va[63], va};
                            4'(fn_sub): wide = {vb[63], vb} - {va[63], va};
                            4'(fn_and): wide = {vb[63] & va[63], vb & va};
                            default:    wide = {vb[63] ^ va[63], vb ^ va};
                        endcase
                        res     = wide[63:0];
                        next_cc = '{zf: res == '0, sf: res[63], of: wide[64] != wide[63]};
                    end
                end
                default: next_status = stat_ins;
            endcase
        end
        if (next_status != stat_aok || rb == REG_NONE) begin
            exp_wb = 1'b0;
        end
        check_flag(wb_en, exp_wb, "wb_en");
        if (exp_wb) begin
            check_reg(wb_reg, rb, "wb_reg");
            check_word(wb_val, res, "wb_val");
            model_regs[rb] = res;
        end
        if (next_status == stat_aok) begin
            model_pc = model_pc + word_t'(len);
        end
        model_status = next_status;
        model_cc     = next_cc;
    endtask

    // nothing may move while run is low
    task automatic hold_run(int cycles);
        @(posedge clk);
        run <= 1'b0;
        repeat (cycles) begin
            @(negedge clk);
            check_flag(wb_en, 1'b0, "wb_en while stopped");
            check_word(pc, model_pc, "pc while stopped");
            check_cc(cc, model_cc, "cc while stopped");
        end
        @(posedge clk);
        run <= 1'b1;
    endtask

    task automatic execute_program(int pause_at, int pause_len);
        int   cycles;
        logic done;

        cycles = 0;
        done   = 1'b0;
        @(posedge clk);
        run <= 1'b1;
        while (!done) begin
            @(negedge clk);
            check_word(pc, model_pc, "pc");
            check_status(status, model_status, "status");
            check_cc(cc, model_cc, "cc");
            if (model_status != stat_aok) begin
                done = 1'b1;
            end else begin
                step_model();
                cycles++;
                if (cycles > MEM_BYTES) begin
                    $display("program kept running past %0d instructions", MEM_BYTES);
                    fail_run();
                end
                if (cycles == pause_at) begin
                    hold_run(pause_len);
                end
            end
        end
        @(posedge clk);
        run <= 1'b0;
    endtask

    task automatic finish_checks(status_t exp_status, word_t exp_pc);
        @(negedge clk);
        check_status(status, exp_status, "final status");
        check_word(pc, exp_pc, "final pc");
        check_cc(cc, model_cc, "final cc");
    endtask

    task automatic irmovq_all_regs();
        word_t halt_pc;

        reset_core();
        prog.delete();
        for (int r = 0; r < 16; r++) begin
            irmovq_instr(4'(r), xorshift64()); // F too, which must not write
        end
        halt_pc = word_t'(prog.size());
        halt_instr();
        load_program();
        execute_program(0, 0);
        finish_checks(stat_hlt, halt_pc);
    endtask

    task automatic rrmovq_and_nop();
        word_t halt_pc;

        reset_core();
        prog.delete();
        irmovq_instr(4'd0, xorshift64());
        irmovq_instr(4'd1, xorshift64());
        nop_instr();
        rrmovq_instr(4'd0, 4'd5);
        nop_instr();
        rrmovq_instr(4'd1, 4'd14);
        rrmovq_instr(4'd5, 4'd1);
        rrmovq_instr(REG_NONE, 4'd3); // reads zero
        rrmovq_instr(4'd2, REG_NONE);
        halt_pc = word_t'(prog.size());
        halt_instr();
        load_program();
        execute_program(0, 0);
        finish_checks(stat_hlt, halt_pc);
    endtask

    task automatic alu_ops();
        word_t r;
        word_t halt_pc;

        reset_core();
        prog.delete();
        for (int i = 0; i < 8; i++) begin
            irmovq_instr(4'(i), xorshift64());
        end
        for (int i = 0; i < 12; i++) begin
            r = xorshift64();
            opq_instr(alu_fn_t'({2'b00, r[1:0]}), {1'b0, r[4:2]}, {1'b0, r[7:5]});
        end
        opq_instr(fn_sub, 4'd4, 4'd4);
        opq_instr(fn_xor, 4'd2, 4'd6);
        // largest positive plus one
        irmovq_instr(4'd10, 64'h7fff_ffff_ffff_ffff);
        irmovq_instr(4'd11, 64'd1);
        opq_instr(fn_add, 4'd11, 4'd10);
        halt_pc = word_t'(prog.size());
        halt_instr();
        load_program();
        execute_program(0, 0);
        finish_checks(stat_hlt, halt_pc);
        check_cc(cc, '{zf: 1'b0, sf: 1'b1, of: 1'b1}, "cc after add overflow");
    endtask

    task automatic invalid_codes();
        logic [7:0] bad [4];

        bad = '{8'h70, 8'hb0, 8'h64, 8'h6f}; // jmp, pop, opq fn 4, opq fn f
        foreach (bad[k]) begin
            reset_core();
            prog.delete();
            irmovq_instr(4'd3, xorshift64());
            nop_instr();
            raw_byte(bad[k]);
            raw_byte(8'h12);
            halt_instr();
            load_program();
            execute_program(0, 0);
            finish_checks(stat_ins, 64'd11);
        end
    endtask

    task automatic memory_end();
        reset_core();
        prog.delete();
        // 25 irmovq fill 250 bytes so the next window ends past memory
        for (int i = 0; i < 25; i++) begin
            irmovq_instr(4'(i % 15), xorshift64());
        end
        load_program();
        execute_program(0, 0);
        finish_checks(stat_adr, word_t'(prog.size()));
    endtask

    task automatic run_pause();
        word_t halt_pc;

        reset_core();
        prog.delete();
        irmovq_instr(4'd0, xorshift64());
        irmovq_instr(4'd1, xorshift64());
        opq_instr(fn_sub, 4'd0, 4'd1);
        nop_instr();
        opq_instr(fn_xor, 4'd1, 4'd0);
        rrmovq_instr(4'd0, 4'd9);
        halt_pc = word_t'(prog.size());
        halt_instr();
        load_program();
        execute_program(4, 6); // paused with the xor up next
        finish_checks(stat_hlt, halt_pc);
    endtask

    initial begin
        reset     = 1'b1;
        run       = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_byte = '0;
        irmovq_all_regs();
        rrmovq_and_nop();
        alu_ops();
        invalid_codes();
        memory_end();
        run_pause();
        $display("sim passed");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        fail_run();
    end

endmodule

// ==== y86_core.f ====
src/y86_pkg.sv
src/instr_memory.sv
src/fetch_unit.sv
src/reg_file.sv
src/execute_unit.sv
src/y86_core.sv
tests/y86_core_tb.sv
